// File: hw/rv_dec_pkg.sv
`default_nettype none

package rv_dec_pkg;

  // Datapath width
  localparam int XLEN = 32;

  // Major opcodes, instr[6:0]
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_RTYPE  = 7'b0110011;
  localparam logic [6:0] OP_ITYPE  = 7'b0010011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // Full-word privileged encodings
  localparam logic [31:0] I_ECALL  = 32'h0000_0073;
  localparam logic [31:0] I_EBREAK = 32'h0010_0073;

  // ALU operand A source
  localparam logic [1:0] ALU_A_RS1  = 2'd0;
  localparam logic [1:0] ALU_A_ZERO = 2'd1;
  localparam logic [1:0] ALU_A_PC   = 2'd2;

  // ALU operand B source
  localparam logic ALU_B_RS2 = 1'b0;
  localparam logic ALU_B_IMM = 1'b1;

  // Writeback result source
  localparam logic [2:0] RES_ALU = 3'd0;
  localparam logic [2:0] RES_MEM = 3'd1;
  localparam logic [2:0] RES_PC4 = 3'd2;
  localparam logic [2:0] RES_TGT = 3'd3;
  localparam logic [2:0] RES_CSR = 3'd4;
  localparam logic [2:0] RES_M   = 3'd5;

  // Immediate formats, NONE for R-type and illegal words
  localparam logic [2:0] IMM_I    = 3'd0;
  localparam logic [2:0] IMM_S    = 3'd1;
  localparam logic [2:0] IMM_B    = 3'd2;
  localparam logic [2:0] IMM_U    = 3'd3;
  localparam logic [2:0] IMM_J    = 3'd4;
  localparam logic [2:0] IMM_NONE = 3'd7;

  // ALU class from the first decode step
  localparam logic [1:0] ALU_INSTR_ADD = 2'd0;
  localparam logic [1:0] ALU_INSTR_FN3 = 2'd1;

  // Resolved ALU operation
  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND
  } alu_op_e;

  // Raw fetch word
  typedef struct packed {
    logic [31:0] word;
  } instr_t;

  // Intermediate decode record
  typedef struct packed {
    logic            reg_write;
    logic            mem_read;
    logic            mem_write;
    logic [1:0]      alu_a_src;
    logic            alu_b_src;
    logic [1:0]      alu_instr;
    logic [2:0]      res_src;
    logic [2:0]      imm_type;
    logic            is_branch;
    logic            is_jal;
    logic            is_jalr;
    logic            is_m;
    logic            is_csr;
    logic            is_ebreak;
    logic            invalid;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic            rs1_used;
    logic            rs2_used;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
  } dec_t;

  // Final micro-op
  typedef struct packed {
    logic            reg_write;
    logic            mem_read;
    logic            mem_write;
    logic [1:0]      alu_a_src;
    logic            alu_b_src;
    alu_op_e         alu_op;
    logic [2:0]      res_src;
    logic            is_branch;
    logic            is_jal;
    logic            is_jalr;
    logic            is_m;
    logic            is_csr;
    logic            is_ebreak;
    logic            invalid;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic            rs1_used;
    logic            rs2_used;
    logic [XLEN-1:0] imm;
  } uop_t;

endpackage

`default_nettype wire

// File: hw/rv_hs_stage.sv
`timescale 1ns/10ps
`default_nettype none

module rv_hs_stage #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     in_req,
  output logic     in_ack,
  input  payload_t in_data,
  output logic     out_req,
  input  logic     out_ack,
  output payload_t out_data
);

  // Stage holds an item from load until the downstream handshake returns to zero
  logic     full;
  logic     load;
  payload_t data_q;

  // New item only when empty and the last input handshake is fully closed
  assign load = !full && in_req && !in_ack;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      full    <= 1'b0;
      in_ack  <= 1'b0;
      out_req <= 1'b0;
    end else if (load) begin
      // Ack upstream and offer downstream on the same edge
      full    <= 1'b1;
      in_ack  <= 1'b1;
      out_req <= 1'b1;
    end else begin
      // Upstream dropped req
      if (in_ack && !in_req) begin
        in_ack <= 1'b0;
      end
      // Downstream took the item
      if (out_req && out_ack) begin
        out_req <= 1'b0;
      end
      // Both sides back at zero, slot is free again
      if (full && !out_req && !out_ack && !in_ack) begin
        full <= 1'b0;
      end
    end
  end

  // Payload only changes while empty, so it is stable under out_req
  always_ff @(posedge clk) begin
    if (load) begin
      data_q <= in_data;
    end
  end

  assign out_data = data_q;

endmodule

`default_nettype wire

// File: hw/rv_idec.sv
`timescale 1ns/10ps
`default_nettype none

module rv_idec import rv_dec_pkg::*; #(
  parameter int ext_m = 1
) (
  input  instr_t instr,
  output dec_t   dec
);

  logic [31:0] w;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [20:0] ctrl;
  logic        valid_op;
  logic        is_m;
  logic        is_ebreak;
  logic        bad_compressed;
  logic        bad_system;
  logic        bad_m;
  logic        invalid;

  assign w      = instr.word;
  assign opcode = w[6:0];
  assign funct3 = w[14:12];
  assign funct7 = w[31:25];

  // Control table, one row per major opcode
  // Fields: valid, rw, mr, mw, a_src, b_src, alu, res, imm, br, jal, jalr, csr, r1u, r2u
  always_comb begin
    case (opcode)
      OP_LOAD:   ctrl = {4'b1110, ALU_A_RS1, ALU_B_IMM, ALU_INSTR_ADD, RES_MEM,
                         IMM_I, 4'b0000, 2'b10};
      OP_STORE:  ctrl = {4'b1001, ALU_A_RS1, ALU_B_IMM, ALU_INSTR_ADD, RES_ALU,
                         IMM_S, 4'b0000, 2'b11};
      OP_RTYPE:  ctrl = {4'b1100, ALU_A_RS1, ALU_B_RS2, ALU_INSTR_FN3, RES_ALU,
                         IMM_NONE, 4'b0000, 2'b11};
      OP_ITYPE:  ctrl = {4'b1100, ALU_A_RS1, ALU_B_IMM, ALU_INSTR_FN3, RES_ALU,
                         IMM_I, 4'b0000, 2'b10};
      // compare only, no writeback
      OP_BRANCH: ctrl = {4'b1000, ALU_A_RS1, ALU_B_RS2, ALU_INSTR_ADD, RES_ALU,
                         IMM_B, 4'b1000, 2'b11};
      OP_JAL:    ctrl = {4'b1100, ALU_A_PC, ALU_B_IMM, ALU_INSTR_ADD, RES_PC4,
                         IMM_J, 4'b0100, 2'b00};
      OP_JALR:   ctrl = {4'b1100, ALU_A_RS1, ALU_B_IMM, ALU_INSTR_ADD, RES_PC4,
                         IMM_I, 4'b0010, 2'b10};
      // PC plus upper immediate goes out as the target result
      OP_AUIPC:  ctrl = {4'b1100, ALU_A_PC, ALU_B_IMM, ALU_INSTR_ADD, RES_TGT,
                         IMM_U, 4'b0000, 2'b00};
      OP_LUI:    ctrl = {4'b1100, ALU_A_ZERO, ALU_B_IMM, ALU_INSTR_ADD, RES_ALU,
                         IMM_U, 4'b0000, 2'b00};
      OP_SYSTEM: ctrl = {4'b1100, ALU_A_RS1, ALU_B_IMM, ALU_INSTR_ADD, RES_CSR,
                         IMM_I, 4'b0001, 2'b10};
      // Unknown opcode, inert row with valid low
      default:   ctrl = {4'b0000, ALU_A_ZERO, ALU_B_RS2, ALU_INSTR_ADD, RES_ALU,
                         IMM_NONE, 4'b0000, 2'b00};
    endcase
  end

  assign valid_op = ctrl[20];

  // M only for the exact funct7 of 0000001
  if (ext_m != 0) begin : g_ext_m
    assign is_m  = (opcode == OP_RTYPE) && (funct7 == 7'b0000001);
    assign bad_m = (opcode == OP_RTYPE) && funct7[0] && (funct7 != 7'b0000001);
  end else begin : g_no_ext_m
    assign is_m  = 1'b0;
    // Every funct7[0] R-type word is outside the base ISA
    assign bad_m = (opcode == OP_RTYPE) && funct7[0];
  end

  assign is_ebreak = (w == I_EBREAK);

  // 16-bit encodings are not supported
  assign bad_compressed = (w[1:0] != 2'b11);

  // funct3 100 is reserved, funct3 000 allows only ECALL and EBREAK
  assign bad_system = (opcode == OP_SYSTEM) &&
                      ((funct3 == 3'b100) ||
                       ((funct3 == 3'b000) && (w != I_ECALL) && (w != I_EBREAK)));

  assign invalid = bad_compressed || !valid_op || bad_system || bad_m;

  always_comb begin
    dec.reg_write = ctrl[19];
    dec.mem_read  = ctrl[18];
    dec.mem_write = ctrl[17];
    dec.alu_a_src = ctrl[16:15];
    dec.alu_b_src = ctrl[14];
    dec.alu_instr = ctrl[13:12];
    // M results come from the multiplier path
    dec.res_src   = is_m ? RES_M : ctrl[11:9];
    dec.imm_type  = ctrl[8:6];
    dec.is_branch = ctrl[5];
    dec.is_jal    = ctrl[4];
    dec.is_jalr   = ctrl[3];
    dec.is_csr    = ctrl[2];
    dec.rs1_used  = ctrl[1];
    dec.rs2_used  = ctrl[0];
    dec.is_m      = is_m;
    dec.is_ebreak = is_ebreak;
    dec.invalid   = invalid;
    // Register fields pass raw, the used flags qualify them
    dec.rd        = w[11:7];
    dec.rs1       = w[19:15];
    dec.rs2       = w[24:20];
    dec.funct3    = funct3;
    dec.funct7    = funct7;
    // All five immediates, sign extended from bit 31
    dec.imm_i     = {{(XLEN - 12) {w[31]}}, w[31:20]};
    dec.imm_s     = {{(XLEN - 12) {w[31]}}, w[31:25], w[11:7]};
    dec.imm_b     = {{(XLEN - 13) {w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    dec.imm_u     = {w[31:12], 12'b0};
    dec.imm_j     = {{(XLEN - 21) {w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
  end

endmodule

`default_nettype wire

// File: hw/rv_alu_dec.sv
`timescale 1ns/10ps
`default_nettype none

module rv_alu_dec import rv_dec_pkg::*; (
  input  dec_t dec,
  output uop_t uop
);

  logic is_rtype;

  // Within the FN3 class only R-type reads rs2 as operand B
  assign is_rtype = (dec.alu_b_src == ALU_B_RS2);

  always_comb begin
    // ALU operation from class, funct3 and funct7[5]
    if (dec.alu_instr == ALU_INSTR_FN3) begin
      case (dec.funct3)
        3'b000:  uop.alu_op = (is_rtype && dec.funct7[5]) ? SUB : ADD;
        3'b001:  uop.alu_op = SLL;
        3'b010:  uop.alu_op = SLT;
        3'b011:  uop.alu_op = SLTU;
        3'b100:  uop.alu_op = XOR;
        // SRAI and SRA share the funct7[5] marker
        3'b101:  uop.alu_op = dec.funct7[5] ? SRA : SRL;
        3'b110:  uop.alu_op = OR;
        default: uop.alu_op = AND;
      endcase
    end else begin
      uop.alu_op = ADD;
    end

    // One immediate per micro-op, zero when no format applies
    case (dec.imm_type)
      IMM_I:   uop.imm = dec.imm_i;
      IMM_S:   uop.imm = dec.imm_s;
      IMM_B:   uop.imm = dec.imm_b;
      IMM_U:   uop.imm = dec.imm_u;
      IMM_J:   uop.imm = dec.imm_j;
      default: uop.imm = '0;
    endcase

    uop.reg_write = dec.reg_write;
    uop.mem_read  = dec.mem_read;
    uop.mem_write = dec.mem_write;
    uop.alu_a_src = dec.alu_a_src;
    uop.alu_b_src = dec.alu_b_src;
    uop.res_src   = dec.res_src;
    uop.is_branch = dec.is_branch;
    uop.is_jal    = dec.is_jal;
    uop.is_jalr   = dec.is_jalr;
    uop.is_m      = dec.is_m;
    uop.is_csr    = dec.is_csr;
    uop.is_ebreak = dec.is_ebreak;
    uop.invalid   = dec.invalid;
    uop.rd        = dec.rd;
    uop.rs1       = dec.rs1;
    uop.rs2       = dec.rs2;
    uop.rs1_used  = dec.rs1_used;
    uop.rs2_used  = dec.rs2_used;
  end

endmodule

`default_nettype wire

// File: hw/rv_dec_top.sv
`timescale 1ns/10ps
`default_nettype none

module rv_dec_top import rv_dec_pkg::*; #(
  parameter int ext_m = 1
) (
  input  logic   clk,
  input  logic   arst_n,
  input  logic   in_req,
  output logic   in_ack,
  input  instr_t in_data,
  output logic   out_req,
  input  logic   out_ack,
  output uop_t   out_data
);

  // Handshake between s_in and s_dec
  logic   req_dec;
  logic   ack_dec;
  // Handshake between s_dec and s_out
  logic   req_out;
  logic   ack_out;

  instr_t instr_q;
  dec_t   dec_d;
  dec_t   dec_q;
  uop_t   uop_d;

  // Stage 1 holds the raw word
  rv_hs_stage #(.payload_t(instr_t)) s_in (
    .clk     (clk),
    .arst_n  (arst_n),
    .in_req  (in_req),
    .in_ack  (in_ack),
    .in_data (in_data),
    .out_req (req_dec),
    .out_ack (ack_dec),
    .out_data(instr_q)
  );

  rv_idec #(.ext_m(ext_m)) u_idec (
    .instr(instr_q),
    .dec  (dec_d)
  );

  // Stage 2 holds the decode record
  rv_hs_stage #(.payload_t(dec_t)) s_dec (
    .clk     (clk),
    .arst_n  (arst_n),
    .in_req  (req_dec),
    .in_ack  (ack_dec),
    .in_data (dec_d),
    .out_req (req_out),
    .out_ack (ack_out),
    .out_data(dec_q)
  );

  rv_alu_dec u_alu_dec (
    .dec(dec_q),
    .uop(uop_d)
  );

  // Stage 3 drives the consumer port
  rv_hs_stage #(.payload_t(uop_t)) s_out (
    .clk     (clk),
    .arst_n  (arst_n),
    .in_req  (req_out),
    .in_ack  (ack_out),
    .in_data (uop_d),
    .out_req (out_req),
    .out_ack (out_ack),
    .out_data(out_data)
  );

endmodule

`default_nettype wire

// File: dv/rv_dec_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rv_dec_tb import rv_dec_pkg::*; ();

  // Base ALU operation per funct3
  localparam alu_op_e fn3_ops [8] = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
  localparam logic [6:0] base_ops [10] = '{OP_LOAD, OP_STORE, OP_RTYPE, OP_ITYPE,
                                           OP_BRANCH, OP_JAL, OP_JALR, OP_AUIPC,
                                           OP_LUI, OP_SYSTEM};
  // One opcode per immediate format with U tested twice
  localparam logic [6:0] imm_ops [6] = '{OP_ITYPE, OP_STORE, OP_BRANCH, OP_LUI,
                                         OP_AUIPC, OP_JAL};

  logic   clk = 1'b0;
  logic   arst_n = 1'b0;
  logic   in_req = 1'b0;
  logic   in_ack;
  instr_t in_data = '0;
  logic   out_req;
  logic   out_ack = 1'b0;
  uop_t   out_data;

  int          seed = 32'h0c3ca95a;
  int          errors = 0;
  int          n_sent = 0;
  int          cycles = 0;
  int          rd_idx = 0;
  logic        stall = 1'b0;
  int          ack_delay = 0;
  logic [31:0] cur_word = '0;
  // Every micro-op taken by the consumer in arrival order
  uop_t        got_q [$];

  rv_dec_top #(.ext_m(1)) uut (
    .clk     (clk),
    .arst_n  (arst_n),
    .in_req  (in_req),
    .in_ack  (in_ack),
    .in_data (in_data),
    .out_req (out_req),
    .out_ack (out_ack),
    .out_data(out_data)
  );

  initial begin
    forever #4 clk = ~clk;
  end

  // Consumer on the output port acks after ack_delay cycles unless stalled
  initial begin : consumer
    int waited;
    waited = 0;
    forever begin
      @(posedge clk);
      if (out_ack) begin
        if (!out_req) out_ack <= 1'b0;
      end else if (out_req && !stall) begin
        if (waited >= ack_delay) begin
          got_q.push_back(out_data);
          out_ack <= 1'b1;
          waited = 0;
        end else begin
          waited++;
        end
      end
    end
  end

  // Limit grows by 40 cycles per issued instruction on top of 200
  initial begin : watchdog
    while (cycles <= 40 * n_sent + 200) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles with %0d instructions issued", cycles, n_sent);
    $display("Finished with %0d errors", errors);
    $display("Something failed");
    $finish;
  end

  task automatic check_field(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR %0t %s expected %h got %h (instr %h)", $time, name, exp, act,
               cur_word);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("ERROR %0t %s expected %b got %b (instr %h)", $time, name, exp, act,
               cur_word);
      errors++;
    end
  endtask

  task automatic check_alu(input string name, input alu_op_e exp, input alu_op_e act);
    if (exp !== act) begin
      $display("ERROR %0t %s expected %s got %s (instr %h)", $time, name, exp.name(),
               act.name(), cur_word);
      errors++;
    end
  endtask

  task automatic check_uop(input uop_t exp, input uop_t act);
    check_field("out_data.reg_write", 32'(exp.reg_write), 32'(act.reg_write));
    check_field("out_data.mem_read", 32'(exp.mem_read), 32'(act.mem_read));
    check_field("out_data.mem_write", 32'(exp.mem_write), 32'(act.mem_write));
    check_field("out_data.alu_a_src", 32'(exp.alu_a_src), 32'(act.alu_a_src));
    check_field("out_data.alu_b_src", 32'(exp.alu_b_src), 32'(act.alu_b_src));
    check_alu("out_data.alu_op", exp.alu_op, act.alu_op);
    check_field("out_data.res_src", 32'(exp.res_src), 32'(act.res_src));
    check_field("out_data.is_branch", 32'(exp.is_branch), 32'(act.is_branch));
    check_field("out_data.is_jal", 32'(exp.is_jal), 32'(act.is_jal));
    check_field("out_data.is_jalr", 32'(exp.is_jalr), 32'(act.is_jalr));
    check_field("out_data.is_m", 32'(exp.is_m), 32'(act.is_m));
    check_field("out_data.is_csr", 32'(exp.is_csr), 32'(act.is_csr));
    check_field("out_data.is_ebreak", 32'(exp.is_ebreak), 32'(act.is_ebreak));
    check_field("out_data.invalid", 32'(exp.invalid), 32'(act.invalid));
    check_field("out_data.rd", 32'(exp.rd), 32'(act.rd));
    check_field("out_data.rs1", 32'(exp.rs1), 32'(act.rs1));
    check_field("out_data.rs2", 32'(exp.rs2), 32'(act.rs2));
    check_field("out_data.rs1_used", 32'(exp.rs1_used), 32'(act.rs1_used));
    check_field("out_data.rs2_used", 32'(exp.rs2_used), 32'(act.rs2_used));
    check_field("out_data.imm", exp.imm, act.imm);
  endtask

  // Expected micro-op straight from the RV32IM encoding rules
  function automatic uop_t ref_uop(input logic [31:0] w);
    uop_t        u;
    logic [6:0]  op;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    op = w[6:0];
    f3 = w[14:12];
    f7 = w[31:25];
    // Sign comes from bit 31 in every format
    imm_i = 32'($signed(w[31:20]));
    imm_s = 32'($signed({w[31:25], w[11:7]}));
    imm_b = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
    imm_u = {w[31:12], 12'h000};
    imm_j = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
    u = '0;
    u.rd = w[11:7];
    u.rs1 = w[19:15];
    u.rs2 = w[24:20];
    u.alu_a_src = ALU_A_RS1;
    u.alu_b_src = ALU_B_IMM;
    u.alu_op = ADD;
    u.res_src = RES_ALU;
    case (op)
      OP_LOAD: begin
        {u.reg_write, u.mem_read, u.rs1_used} = 3'b111;
        u.res_src = RES_MEM;
        u.imm = imm_i;
      end
      OP_STORE: begin
        {u.mem_write, u.rs1_used, u.rs2_used} = 3'b111;
        u.imm = imm_s;
      end
      OP_RTYPE: begin
        {u.reg_write, u.rs1_used, u.rs2_used} = 3'b111;
        u.alu_b_src = ALU_B_RS2;
      end
      OP_ITYPE: begin
        {u.reg_write, u.rs1_used} = 2'b11;
        u.imm = imm_i;
      end
      // Compare only with nothing written back
      OP_BRANCH: begin
        {u.is_branch, u.rs1_used, u.rs2_used} = 3'b111;
        u.alu_b_src = ALU_B_RS2;
        u.imm = imm_b;
      end
      OP_JAL: begin
        {u.reg_write, u.is_jal} = 2'b11;
        u.alu_a_src = ALU_A_PC;
        u.res_src = RES_PC4;
        u.imm = imm_j;
      end
      OP_JALR: begin
        {u.reg_write, u.is_jalr, u.rs1_used} = 3'b111;
        u.res_src = RES_PC4;
        u.imm = imm_i;
      end
      OP_AUIPC: begin
        u.reg_write = 1'b1;
        u.alu_a_src = ALU_A_PC;
        u.res_src = RES_TGT;
        u.imm = imm_u;
      end
      OP_LUI: begin
        u.reg_write = 1'b1;
        u.alu_a_src = ALU_A_ZERO;
        u.imm = imm_u;
      end
      OP_SYSTEM: begin
        {u.reg_write, u.is_csr, u.rs1_used} = 3'b111;
        u.res_src = RES_CSR;
        u.imm = imm_i;
      end
      default: begin
        u.alu_a_src = ALU_A_ZERO;
        u.alu_b_src = ALU_B_RS2;
      end
    endcase
    if (op == OP_RTYPE || op == OP_ITYPE) begin
      u.alu_op = fn3_ops[f3];
      // SUB exists only in register form
      if (op == OP_RTYPE && f3 == 3'b000 && f7[5]) u.alu_op = SUB;
      if (f3 == 3'b101 && f7[5]) u.alu_op = SRA;
    end
    // DUT built with the M extension
    u.is_m = (op == OP_RTYPE) && (f7 == 7'b0000001);
    if (u.is_m) u.res_src = RES_M;
    u.is_ebreak = (w == I_EBREAK);
    u.invalid = (w[1:0] != 2'b11) ||
                !(op inside {OP_LOAD, OP_STORE, OP_RTYPE, OP_ITYPE, OP_BRANCH,
                             OP_JAL, OP_JALR, OP_AUIPC, OP_LUI, OP_SYSTEM}) ||
                (op == OP_SYSTEM && f3 == 3'b100) ||
                (op == OP_SYSTEM && f3 == 3'b000 && w != I_ECALL && w != I_EBREAK) ||
                (op == OP_RTYPE && f7[0] && !u.is_m);
    return u;
  endfunction

  // Legal word for an opcode with random remaining fields
  function automatic logic [31:0] legal_word(input logic [6:0] op, input logic [31:0] r);
    logic [31:0] w;
    w = {r[31:7], op};
    if (op == OP_RTYPE) w[31:25] = r[31] ? 7'b0000001 : {1'b0, r[30], 5'b00000};
    // CSR forms only with funct3 001 or 101
    if (op == OP_SYSTEM) w[14:12] = {r[14], 2'b01};
    return w;
  endfunction

  task automatic start_send(input logic [31:0] w);
    @(posedge clk);
    cur_word = w;
    in_data.word <= w;
    in_req <= 1'b1;
    n_sent <= n_sent + 1;
  endtask

  // Rest of the four-phase cycle after req is up
  task automatic finish_send();
    do @(posedge clk); while (!in_ack);
    in_req <= 1'b0;
    do @(posedge clk); while (in_ack);
  endtask

  task automatic send_word(input logic [31:0] w);
    start_send(w);
    finish_send();
  endtask

  task automatic get_uop(output uop_t got);
    while (got_q.size() <= rd_idx) @(posedge clk);
    got = got_q[rd_idx];
    rd_idx++;
  endtask

  task automatic run_word(input logic [31:0] w, output uop_t got);
    send_word(w);
    get_uop(got);
    check_uop(ref_uop(w), got);
  endtask

  task automatic expect_invalid(input logic [31:0] w, input logic exp);
    uop_t got;
    run_word(w, got);
    check_bit("out_data.invalid", exp, got.invalid);
  endtask

  task automatic test_reset_latency();
    uop_t got;
    @(posedge clk);
    check_bit("in_ack", 1'b0, in_ack);
    check_bit("out_req", 1'b0, out_req);
    start_send(32'h02a00293);
    // Reads at an edge see the value from just before it
    repeat (3) begin
      @(posedge clk);
      check_bit("out_req", 1'b0, out_req);
    end
    @(posedge clk);
    check_bit("out_req", 1'b1, out_req);
    finish_send();
    get_uop(got);
    check_uop(ref_uop(32'h02a00293), got);
  endtask

  task automatic test_opcodes();
    uop_t got;
    for (int i = 0; i < 10; i++) begin
      run_word(legal_word(base_ops[i], $random(seed)), got);
      check_bit("out_data.invalid", 1'b0, got.invalid);
    end
  endtask

  task automatic test_immediates();
    uop_t        got;
    logic [31:0] r;
    for (int i = 0; i < 6; i++) begin
      for (int s = 0; s < 2; s++) begin
        r = $random(seed);
        r[31] = s[0];
        run_word(legal_word(imm_ops[i], r), got);
      end
    end
    // ADDI x1, x0, -1 and JAL x1, -4
    run_word(32'hfff00093, got);
    check_field("out_data.imm", 32'hffffffff, got.imm);
    run_word(32'hffdff0ef, got);
    check_field("out_data.imm", 32'hfffffffc, got.imm);
  endtask

  task automatic test_alu_ops();
    uop_t        got;
    logic [31:0] r;
    for (int f = 0; f < 8; f++) begin
      r = $random(seed);
      run_word({7'b0000000, r[24:15], 3'(f), r[11:7], OP_RTYPE}, got);
      check_alu("out_data.alu_op", fn3_ops[f], got.alu_op);
      // Bit 30 turns SRLI into SRAI but leaves ADDI as ADD
      for (int s = 0; s < 2; s++) begin
        run_word({1'b0, s[0], r[29:15], 3'(f), r[11:7], OP_ITYPE}, got);
        check_alu("out_data.alu_op", (f == 5 && s == 1) ? SRA : fn3_ops[f], got.alu_op);
      end
      // MUL through REMU
      run_word({7'b0000001, r[24:15], 3'(f), r[11:7], OP_RTYPE}, got);
      check_bit("out_data.is_m", 1'b1, got.is_m);
      check_field("out_data.res_src", 32'(RES_M), 32'(got.res_src));
      check_bit("out_data.invalid", 1'b0, got.invalid);
    end
    r = $random(seed);
    run_word({7'b0100000, r[24:15], 3'b000, r[11:7], OP_RTYPE}, got);
    check_alu("out_data.alu_op", SUB, got.alu_op);
    run_word({7'b0100000, r[24:15], 3'b101, r[11:7], OP_RTYPE}, got);
    check_alu("out_data.alu_op", SRA, got.alu_op);
  endtask

  task automatic test_illegal();
    uop_t        got;
    logic [31:0] r;
    for (int i = 0; i < 3; i++) begin
      r = $random(seed);
      expect_invalid({r[31:2], 2'(i)}, 1'b1);
    end
    r = $random(seed);
    // FENCE, AMO and an all-ones opcode are not decoded
    expect_invalid({r[31:7], 7'b0001111}, 1'b1);
    expect_invalid({r[31:7], 7'b0101111}, 1'b1);
    expect_invalid({r[31:7], 7'b1111111}, 1'b1);
    expect_invalid({r[31:15], 3'b100, r[11:7], OP_SYSTEM}, 1'b1);
    // MRET and WFI
    expect_invalid(32'h30200073, 1'b1);
    expect_invalid(32'h10500073, 1'b1);
    expect_invalid({7'b0000011, r[24:15], 3'b000, r[11:7], OP_RTYPE}, 1'b1);
    expect_invalid({7'b0100001, r[24:15], 3'b101, r[11:7], OP_RTYPE}, 1'b1);
    run_word(I_ECALL, got);
    check_bit("out_data.invalid", 1'b0, got.invalid);
    check_bit("out_data.is_ebreak", 1'b0, got.is_ebreak);
    run_word(I_EBREAK, got);
    check_bit("out_data.invalid", 1'b0, got.invalid);
    check_bit("out_data.is_ebreak", 1'b1, got.is_ebreak);
  endtask

  task automatic test_backpressure();
    logic [31:0] sent [$];
    logic [31:0] w;
    int          k;
    stall <= 1'b1;
    // Three stages fill up with one item each
    for (int i = 0; i < 30; i++) begin
      k = $unsigned($random(seed)) % 10;
      w = legal_word(base_ops[k], $random(seed));
      sent.push_back(w);
      if (i < 3) begin
        send_word(w);
      end else if (i == 3) begin
        start_send(w);
        repeat (20) @(posedge clk);
        check_bit("in_ack", 1'b0, in_ack);
        check_bit("out_req", 1'b1, out_req);
        // Oldest word waits at the output while the consumer is stalled
        cur_word = sent[0];
        check_uop(ref_uop(sent[0]), out_data);
        stall <= 1'b0;
        ack_delay <= 2;
        finish_send();
      end else begin
        send_word(w);
      end
    end
    while (got_q.size() < rd_idx + 30) @(posedge clk);
    for (int i = 0; i < 30; i++) begin
      cur_word = sent[i];
      check_uop(ref_uop(sent[i]), got_q[rd_idx]);
      rd_idx++;
    end
  endtask

  initial begin
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    test_reset_latency();
    test_opcodes();
    test_immediates();
    test_alu_ops();
    test_illegal();
    test_backpressure();
    repeat (4) @(posedge clk);
    $display("Finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
hw/rv_dec_pkg.sv
hw/rv_hs_stage.sv
hw/rv_idec.sv
hw/rv_alu_dec.sv
hw/rv_dec_top.sv
dv/rv_dec_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the decode pipeline testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 \
  --top-module rv_dec_tb \
  -f tb.f \
  -o rv_dec_sim

./obj_dir/rv_dec_sim | tee sim.log

if grep -q "Everything OK" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
